// File: floor_controller.f
logic/elevator_pkg.sv
logic/request_latch.sv
logic/target_selector.sv
logic/dispatcher.sv
logic/floor_controller.sv
verification/car_model.sv
verification/floor_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the floor controller testbench with Verilator and run it.
# The run counts as failed when the log holds the fail message
# or lacks the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f floor_controller.f \
    --top-module floor_controller_tb \
    -o floor_controller_sim

./obj_dir/floor_controller_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: verification/floor_controller_tb.sv
// Testbench for the elevator floor-request controller.
// Runs directed tests for reset, latching, dispatch, arrival and door
// permits, then random traffic. Concurrent assertions compare the DUT
// against a request model and a nearest-request reference.

`timescale 1ns/10ps

module floor_controller_tb import elevator_pkg::*; ();

    localparam int DIRECTED_TESTS = 5;
    localparam int RANDOM_TRIPS   = 30;
    localparam int WATCHDOG_CYCLES = DIRECTED_TESTS * 200 + RANDOM_TRIPS * 400;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    car_status_t car;
    dispatch_t   dispatch;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Reference state
    floor_mask_t exp_call;
    floor_mask_t exp_panel;
    logic        exp_found;
    floor_t      exp_target;
    dir_e        exp_dir;
    dir_e        ref_dir;
    logic        enabled_tb;
    logic        probe;
    logic        quiet;
    int          errors;
    int          tests_done;
    int          test_start_errors;

    floor_controller floor_controller_i (.*);

    car_model car_model_i (
        .clock    (clock),
        .reset_n  (reset_n),
        .dispatch (dispatch),
        .car      (car)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Nearest request on the preferred side first and on the other side after
    function automatic logic [4:0] nearest_request(floor_mask_t req, floor_t cur, dir_e pref);
        int f;
        for (int side = 0; side < 2; side++) begin
            for (int d = 1; d < NUM_FLOORS; d++) begin
                f = ((pref == DIR_UP) == (side == 0)) ? int'(cur) + d : int'(cur) - d;
                if (f >= 0 && f < NUM_FLOORS && req[f]) begin
                    return {1'b1, floor_t'(f)};
                end
            end
        end
        return 5'd0;
    endfunction

    assign enabled_tb = power_switch && !emergency_btn;
    assign {exp_found, exp_target} = nearest_request(exp_call | exp_panel, car.floor, ref_dir);
    assign exp_dir = (exp_target > car.floor) ? DIR_UP : DIR_DOWN;

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            exp_call  <= '0;
            exp_panel <= '0;
            ref_dir   <= DIR_UP;
        end else begin
            if (enabled_tb) begin
                for (int f = 0; f < NUM_FLOORS; f++) begin
                    if (!car.moving && floor_t'(f) == car.floor) begin
                        exp_call[f]  <= 1'b0;
                        exp_panel[f] <= 1'b0;
                    end else begin
                        exp_call[f]  <= exp_call[f] | floor_call_buttons[f];
                        exp_panel[f] <= exp_panel[f] | panel_buttons[f];
                    end
                end
            end
            // The car is still at its start floor while activate is high
            if (dispatch.activate) begin
                ref_dir <= (dispatch.target > car.floor) ? DIR_UP : DIR_DOWN;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_call: assert property (@(posedge clock) disable iff (!reset_n)
        call_button_lights == exp_call)
        else begin
            errors++;
            $display("MISMATCH call_button_lights got %h expected %h",
                $sampled(call_button_lights), $sampled(exp_call));
        end

    a_panel: assert property (@(posedge clock) disable iff (!reset_n)
        panel_button_lights == exp_panel)
        else begin
            errors++;
            $display("MISMATCH panel_button_lights got %h expected %h",
                $sampled(panel_button_lights), $sampled(exp_panel));
        end

    a_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        dispatch.activate |=> !dispatch.activate)
        else begin
            errors++;
            $display("activate stayed high for more than one cycle");
        end

    a_found: assert property (@(posedge clock) disable iff (!reset_n)
        dispatch.activate |-> $past(exp_found))
        else begin
            errors++;
            $display("activate issued with no request pending");
        end

    a_target: assert property (@(posedge clock) disable iff (!reset_n)
        dispatch.activate |-> dispatch.target == $past(exp_target))
        else begin
            errors++;
            $display("MISMATCH dispatch.target got %h expected %h",
                $sampled(dispatch.target), $past(exp_target));
        end

    a_dir: assert property (@(posedge clock) disable iff (!reset_n)
        dispatch.activate |-> dispatch.direction == $past(exp_dir))
        else begin
            errors++;
            $display("MISMATCH dispatch.direction got %h expected %h",
                $sampled(dispatch.direction), $past(exp_dir));
        end

    // Single press into an idle car
    a_latency: assert property (@(posedge clock) disable iff (!reset_n)
        $past(probe, 2) |-> dispatch.activate)
        else begin
            errors++;
            $display("activate did not follow two cycles after the press");
        end

    a_door_open: assert property (@(posedge clock) disable iff (!reset_n)
        door_open_allowed == $past(power_switch && !car.moving && door_open_btn))
        else begin
            errors++;
            $display("MISMATCH door_open_allowed got %h expected %h",
                $sampled(door_open_allowed),
                $past(power_switch && !car.moving && door_open_btn));
        end

    a_door_close: assert property (@(posedge clock) disable iff (!reset_n)
        door_close_allowed == $past(power_switch && !car.moving && door_close_btn))
        else begin
            errors++;
            $display("MISMATCH door_close_allowed got %h expected %h",
                $sampled(door_close_allowed),
                $past(power_switch && !car.moving && door_close_btn));
        end

    a_quiet: assert property (@(posedge clock) disable iff (!reset_n)
        quiet |-> !dispatch.activate && (call_button_lights | panel_button_lights) == '0)
        else begin
            errors++;
            $display("activity after traffic stopped");
        end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic press(floor_mask_t hall, floor_mask_t panel, logic latency_check);
        @(negedge clock);
        floor_call_buttons = hall;
        panel_buttons      = panel;
        probe              = latency_check;
        @(negedge clock);
        floor_call_buttons = '0;
        panel_buttons      = '0;
        probe              = 1'b0;
    endtask

    // Wait until no request is lit and the car has stood still a while
    task automatic wait_settled(int max_cycles);
        int still;
        still = 0;
        for (int i = 0; i < max_cycles && still < 8; i++) begin
            @(negedge clock);
            if ((exp_call | exp_panel) == '0 && !car.moving && !dispatch.activate) begin
                still++;
            end else begin
                still = 0;
            end
        end
        if (still < 8) begin
            errors++;
            $display("requests were not served within %0d cycles", max_cycles);
        end
    endtask

    task automatic end_test(string name);
        tests_done++;
        $display("test %s done with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int trips;
        void'($urandom(32'h55d73e71));
        reset_n = 1'b0;
        floor_call_buttons = '0;
        panel_buttons = '0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn = 1'b0;
        power_switch = 1'b1;
        probe = 1'b0;
        quiet = 1'b0;
        errors = 0;
        tests_done = 0;
        test_start_errors = 0;
        repeat (5) @(negedge clock);
        reset_n = 1'b1;

        @(negedge clock);
        assert (dispatch == dispatch_t'{target: 4'd0, direction: DIR_UP, activate: 1'b0})
        else begin
            errors++;
            $display("MISMATCH dispatch got %h expected %h", dispatch, 6'b000010);
        end
        assert (call_button_lights == '0 && panel_button_lights == '0
                && !door_open_allowed && !door_close_allowed)
        else begin
            errors++;
            $display("lights or door permits not low after reset");
        end
        end_test("reset");

        // Bring the car to floor 3 and check the press-to-activate latency
        press('0, floor_mask_t'(1) << 3, 1'b1);
        wait_settled(200);
        emergency_btn = 1'b1;
        press(floor_mask_t'(1) << 5, floor_mask_t'(1) << 5, 1'b0);
        emergency_btn = 1'b0;
        power_switch = 1'b0;
        press(floor_mask_t'(1) << 5, floor_mask_t'(1) << 5, 1'b0);
        power_switch = 1'b1;
        press(floor_mask_t'(1) << 3, floor_mask_t'(1) << 3, 1'b0);
        press(floor_mask_t'(1) << 7, floor_mask_t'(1) << 1, 1'b0);
        wait_settled(400);
        end_test("latching and dispatch");

        // Both banks at one floor
        press(floor_mask_t'(1) << 8, floor_mask_t'(1) << 8, 1'b1);
        press(floor_mask_t'(1) << 2, '0, 1'b0);
        wait_settled(400);
        end_test("arrival clearing");

        door_open_btn = 1'b1;
        repeat (4) @(negedge clock);
        door_open_btn = 1'b0;
        door_close_btn = 1'b1;
        repeat (4) @(negedge clock);
        door_open_btn = 1'b1;
        press('0, floor_mask_t'(1) << 6, 1'b0);
        repeat (20) @(negedge clock);
        wait_settled(200);
        power_switch = 1'b0;
        repeat (4) @(negedge clock);
        power_switch = 1'b1;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        @(negedge clock);
        end_test("door permits");

        trips = 0;
        while (trips < RANDOM_TRIPS) begin
            @(negedge clock);
            if (dispatch.activate) begin
                trips++;
            end
            floor_call_buttons = '0;
            panel_buttons = '0;
            if ($urandom % 8 == 0) begin
                if ($urandom % 2 == 0) begin
                    floor_call_buttons = floor_mask_t'(1) << ($urandom % NUM_FLOORS);
                end else begin
                    panel_buttons = floor_mask_t'(1) << ($urandom % NUM_FLOORS);
                end
            end
            door_open_btn = ($urandom % 4 == 0);
            door_close_btn = ($urandom % 4 == 0);
        end
        floor_call_buttons = '0;
        panel_buttons = '0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        wait_settled(2000);
        quiet = 1'b1;
        repeat (50) @(negedge clock);
        quiet = 1'b0;
        end_test("random traffic");

        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verification/car_model.sv
// Behavioral elevator car for the floor controller testbench.
// Starts moving two cycles after an activate strobe, steps one floor
// every four cycles toward the target and stops there.
// Drives its status on falling clock edges.

`timescale 1ns/10ps

module car_model import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  dispatch_t   dispatch,
    output car_status_t car
);

    floor_t goal;
    floor_t next_floor;
    logic   starting;
    int     start_cnt;
    int     step_cnt;

    // One floor closer to the goal
    assign next_floor = (goal > car.floor) ? car.floor + 4'd1 : car.floor - 4'd1;

    always @(negedge clock or negedge reset_n) begin
        if (!reset_n) begin
            car       <= '0;
            goal      <= '0;
            starting  <= 1'b0;
            start_cnt <= 0;
            step_cnt  <= 0;
        end else if (starting) begin
            if (start_cnt == 1) begin
                car.moving <= 1'b1;
                starting   <= 1'b0;
                step_cnt   <= 4;
            end else begin
                start_cnt <= start_cnt - 1;
            end
        end else if (car.moving) begin
            if (step_cnt == 1) begin
                car.floor <= next_floor;
                step_cnt  <= 4;
                if (next_floor == goal) begin
                    car.moving <= 1'b0;
                end
            end else begin
                step_cnt <= step_cnt - 1;
            end
        end else if (dispatch.activate && dispatch.target != car.floor) begin
            // Trip to the own floor is ignored
            goal      <= dispatch.target;
            starting  <= 1'b1;
            start_cnt <= 2;
        end
    end

endmodule

// File: logic/floor_controller.sv
// Top level of the elevator floor-request controller.
// Latches hall and panel requests, picks the next target, dispatches it
// to the car and grants door permits while the car is stopped.
// The car mechanism sits outside and reports back through car.

`timescale 1ns/10ps

module floor_controller import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    input  car_status_t car,
    output dispatch_t   dispatch,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    logic        enabled;
    floor_mask_t pending;
    logic        found;
    floor_t      chosen;
    dir_e        last_direction;

    // Requests and dispatch run only with power on and no emergency
    assign enabled = power_switch && !emergency_btn;

    //////////////////////////////////////////////////////////////////////
    // Request banks
    //////////////////////////////////////////////////////////////////////

    request_latch hall_requests (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (floor_call_buttons),
        .car     (car),
        .enabled (enabled),
        .lights  (call_button_lights)
    );

    request_latch panel_requests (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (panel_buttons),
        .car     (car),
        .enabled (enabled),
        .lights  (panel_button_lights)
    );

    // A floor is wanted if either bank has it lit
    assign pending = call_button_lights | panel_button_lights;

    //////////////////////////////////////////////////////////////////////
    // Selection and dispatch
    //////////////////////////////////////////////////////////////////////

    target_selector target_selector_i (
        .pending   (pending),
        .current   (car.floor),
        .preferred (last_direction),
        .found     (found),
        .target    (chosen)
    );

    dispatcher dispatcher_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .found          (found),
        .chosen         (chosen),
        .car            (car),
        .enabled        (enabled),
        .last_direction (last_direction),
        .dispatch       (dispatch)
    );

    //////////////////////////////////////////////////////////////////////
    // Door permits
    //////////////////////////////////////////////////////////////////////

    // Emergency does not block the doors, only power and motion do
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= power_switch && !car.moving && door_open_btn;
            door_close_allowed <= power_switch && !car.moving && door_close_btn;
        end
    end

endmodule

// File: logic/dispatcher.sv
// Sends one target at a time to the car and follows the trip.
// On a found request while stopped it registers the target and
// direction and strobes activate for one cycle, then waits for the car
// to start and stop again before it looks at the requests once more.
// The direction register doubles as the preference for the next search.

`timescale 1ns/10ps

module dispatcher import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        found,
    input  floor_t      chosen,
    input  car_status_t car,
    input  logic        enabled,
    output dir_e        last_direction,
    output dispatch_t   dispatch
);

    disp_state_e state;

    // Command registers
    floor_t target_q;
    dir_e   direction_q;
    logic   activate_q;

    // New trip may begin this cycle
    logic start;

    assign start = enabled && !car.moving && found;

    //////////////////////////////////////////////////////////////////////
    // Trip FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state       <= DISP_IDLE;
            target_q    <= '0;
            direction_q <= DIR_UP;
            activate_q  <= 1'b0;
        end else begin
            // Strobe lasts a single cycle
            activate_q <= 1'b0;

            case (state)
                DISP_IDLE: begin
                    if (start) begin
                        target_q    <= chosen;
                        direction_q <= (chosen > car.floor) ? DIR_UP : DIR_DOWN;
                        activate_q  <= 1'b1;
                        state       <= DISP_WAIT_MOVE;
                    end
                end

                // The car acknowledges only by starting to move
                DISP_WAIT_MOVE: begin
                    if (car.moving) begin
                        state <= DISP_WAIT_ARRIVE;
                    end else if (!enabled) begin
                        // Abandon the trip on power loss or emergency
                        state <= DISP_IDLE;
                    end
                end

                DISP_WAIT_ARRIVE: begin
                    if (!car.moving) begin
                        state <= DISP_IDLE;
                    end
                end

                default: begin
                    state <= DISP_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    assign dispatch = '{
        target:    target_q,
        direction: direction_q,
        activate:  activate_q
    };

    assign last_direction = direction_q;

endmodule

// File: logic/target_selector.sv
// Picks the next target floor from the pending requests.
// Looks for the nearest request in the preferred direction first and
// falls back to the nearest one in the other direction. Purely
// combinational; found is low when nothing but the current floor is set.

`timescale 1ns/10ps

module target_selector import elevator_pkg::*; (
    input  floor_mask_t pending,
    input  floor_t      current,
    input  dir_e        preferred,
    output logic        found,
    output floor_t      target
);

    // Nearest request above and below the current floor
    logic   above_hit;
    logic   below_hit;
    floor_t above_floor;
    floor_t below_floor;

    //////////////////////////////////////////////////////////////////////
    // Search
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        above_hit   = 1'b0;
        below_hit   = 1'b0;
        above_floor = '0;
        below_floor = '0;

        // Walk upward from floor 0
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (pending[i]) begin
                if (floor_t'(i) < current) begin
                    // Last hit below is the highest one below
                    below_hit   = 1'b1;
                    below_floor = floor_t'(i);
                end else if (floor_t'(i) > current && !above_hit) begin
                    // First hit above is the lowest one above
                    above_hit   = 1'b1;
                    above_floor = floor_t'(i);
                end
                // The current floor itself is skipped
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Direction preference
    //////////////////////////////////////////////////////////////////////

    assign found = above_hit | below_hit;

    always_comb begin
        if (preferred == DIR_UP) begin
            target = above_hit ? above_floor : below_floor;
        end else begin
            target = below_hit ? below_floor : above_floor;
        end
    end

endmodule

// File: logic/request_latch.sv
// One bank of latched floor requests.
// A press sets the floor's light, and the light of the floor where the
// car stands still is cleared. Used once for the hall call buttons and
// once for the car panel buttons.

`timescale 1ns/10ps

module request_latch import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t buttons,
    input  car_status_t car,
    input  logic        enabled,
    output floor_mask_t lights
);

    // Bit of the floor where the car is stopped, empty while moving
    floor_mask_t stop_mask;
    floor_mask_t next_lights;

    //////////////////////////////////////////////////////////////////////
    // Set and clear
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        stop_mask = '0;
        if (!car.moving) begin
            // Shift gives an empty mask for a floor number above the top
            stop_mask = floor_mask_t'(1) << car.floor;
        end
    end

    // Clear wins over a press at the stopped floor, so a press there
    // never lights and a standing request goes out in the same cycle
    assign next_lights = (lights | buttons) & ~stop_mask;

    //////////////////////////////////////////////////////////////////////
    // Request register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else if (enabled) begin
            lights <= next_lights;
        end
        // With power off or emergency the lights hold
    end

endmodule

// File: logic/elevator_pkg.sv
// Shared types for the elevator floor-request controller.
// Holds the floor count, floor and mask types, the direction and
// dispatcher state encodings, and the car status and dispatch structs.
// Every design and testbench file pulls this in with a wildcard import.

package elevator_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    // Floors 0 to 10, lowest first
    localparam int NUM_FLOORS = 11;

    // Enough bits to number every floor
    localparam int FLOOR_W = 4;

    typedef logic [FLOOR_W-1:0] floor_t;

    // One bit per floor for buttons, lights and pending requests
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_e;

    typedef enum logic [1:0] {
        DISP_IDLE        = 2'd0,
        DISP_WAIT_MOVE   = 2'd1,
        DISP_WAIT_ARRIVE = 2'd2
    } disp_state_e;

    //////////////////////////////////////////////////////////////////////
    // Car interface
    //////////////////////////////////////////////////////////////////////

    // Status reported by the car mechanism
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

    // Command to the car mechanism, activate is a one-cycle strobe
    typedef struct packed {
        floor_t target;
        dir_e   direction;
        logic   activate;
    } dispatch_t;

endpackage
